// File: vlog.f
+incdir+.
cpu_pkg.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
executeStage.sv
singleCpu.sv
tb_singleCpu.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the singleCpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_singleCpu --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: tb_singleCpu.sv
`include "cpu_consts.svh"

module tb_singleCpu import cpu_pkg::*; ();

    localparam int NUM_RETIRE  = 128;                          // Two passes through imem
    localparam int CYCLE_LIMIT = 10 + 64 + NUM_RETIRE + 3 + 50;

    logic                 CLK = 1'b0;
    logic                 RST;
    logic                 progWrite;
    logic [`IMEM_AW-1:0]  progAddr;
    logic [`CPU_XLEN-1:0] progData;
    retire_t              retire;

    logic [31:0] prog [`IMEM_WORDS];
    logic [31:0] mRegs [`CPU_REGS];     // Golden model state
    logic [31:0] mMem [`DMEM_WORDS];
    logic [31:0] mPc;
    logic [31:0] lfsr;
    logic [4:0]  prevRd;                // 0 when the last instruction wrote nothing
    bit          x0Written;
    int          retired;
    int          lowCycles;
    int          cycleCount;
    int          checks [1:6];
    int          fails [1:6];

    singleCpu uut (
        .CLK       (CLK),
        .RST       (RST),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .retire    (retire)
    );

    initial begin
        forever #4 CLK = ~CLK;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] encR(input logic b30, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
        return {1'b0, b30, 5'b0, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw with base x0
    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, `F3_WORD, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [11:0] memImm(input logic [2:0] idx, input logic [1:0] sel);
        logic [11:0] base;
        base = {7'b0, idx, 2'b00};
        case (sel)
            2'd0:    return base;
            2'd1:    return base + 12'h100;
            2'd2:    return base + 12'hF00;   // Negative address with the same word index
            default: return base + 12'h200;
        endcase
    endfunction

    function automatic logic [31:0] aluRef(input logic alt, input logic [2:0] f3,
                                           input logic [31:0] a, b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic buildProgram();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        bit          written [8];       // Loads only hit words already stored
        foreach (written[k]) written[k] = 1'b0;
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            drawBits(32, r);
            f3  = r[4:2];
            imm = r[26:15];
            rd  = {2'b0, r[8:6]};
            rs1 = {2'b0, r[11:9]};
            rs2 = {2'b0, r[14:12]};
            case (i)
                4:  prog[i] = encS(memImm(3'd5, 2'd2), 5'd3);
                5:  prog[i] = encI(memImm(3'd5, 2'd0), `F3_WORD, 5'd4, 5'd0, `OPC_LOAD);
                10: prog[i] = encI(12'd123, `F3_ADD, 5'd0, 5'd5, `OPC_OPIMM);  // addi x0
                11: prog[i] = encR(1'b0, `F3_ADD, 5'd6, 5'd0, 5'd5);
                20: prog[i] = encR(1'b0, `F3_ADD, 5'd1, 5'd2, 5'd3);   // Dependent add chain
                21: prog[i] = encR(1'b0, `F3_ADD, 5'd2, 5'd1, 5'd1);
                22: prog[i] = encR(1'b0, `F3_ADD, 5'd3, 5'd2, 5'd1);
                default: begin
                    if (r[1:0] == 2'd0) begin
                        prog[i] = encR(r[5] && (f3 == `F3_ADD || f3 == `F3_SR), f3, rd, rs1, rs2);
                    end else if (r[1:0] == 2'd1) begin
                        if (f3 == `F3_SLL) imm = {7'b0, imm[4:0]};
                        if (f3 == `F3_SR) imm = {1'b0, r[5], 5'b0, imm[4:0]};
                        prog[i] = encI(imm, f3, rd, rs1, `OPC_OPIMM);
                    end else if (r[1:0] == 2'd2 && written[r[29:27]]) begin
                        prog[i] = encI(memImm(r[29:27], r[31:30]), `F3_WORD, rd, 5'd0, `OPC_LOAD);
                    end else begin
                        prog[i] = encS(memImm(r[29:27], r[31:30]), rs2);
                        written[r[29:27]] = 1'b1;
                    end
                end
            endcase
            if (i == 4) written[5] = 1'b1;
        end
    endtask

    task automatic record(input int b, input bit ok);
        checks[b]++;
        if (!ok) fails[b]++;
    endtask

    task automatic checkField(input int b, input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else
            $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
        record(b, act === exp);
    endtask

    // Steps the model one instruction and compares the retire record
    task automatic checkRetire();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [6:0]  opc;
        logic [4:0]  rd;
        bit          isStore;
        bit          wr;
        bit          dep;
        bit          readsX0;
        int          beh;
        ins     = prog[mPc[7:2]];
        opc     = ins[6:0];
        rd      = ins[11:7];
        a       = mRegs[ins[19:15]];
        b       = mRegs[ins[24:20]];
        isStore = (opc == `OPC_STORE);
        dep     = prevRd != 0 &&
                  (ins[19:15] == prevRd || (opc == `OPC_OP && ins[24:20] == prevRd));
        readsX0 = x0Written && (ins[19:15] == 0 || (opc == `OPC_OP && ins[24:20] == 0));
        addr    = '0;
        res     = '0;
        case (opc)
            `OPC_OP: begin
                beh = 2;
                res = aluRef(ins[30], ins[14:12], a, b);
            end
            `OPC_OPIMM: begin
                beh = 3;
                res = aluRef(ins[30] && ins[14:12] == `F3_SR, ins[14:12], a,
                             {{20{ins[31]}}, ins[31:20]});
            end
            `OPC_LOAD: begin
                beh  = 5;
                addr = a + {{20{ins[31]}}, ins[31:20]};
                res  = mMem[addr[7:2]];     // Word index wraps at 64
            end
            default: begin
                beh  = 5;
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
        endcase
        wr = !isStore && rd != 0;
        checkField(1, "retire.pc", mPc, retire.pc);
        checkField(1, "retire.instr", ins, retire.instr);
        checkField((!isStore && rd == 0) ? 6 : beh, "retire.rdWrite", wr, retire.rdWrite);
        if (wr) begin
            checkField(beh, "retire.rdAddr", rd, retire.rdAddr);
            checkField(beh, "retire.rdData", res, retire.rdData);
            if (dep) record(4, retire.rdData === res);
            if (readsX0) record(6, retire.rdData === res);
            mRegs[rd] = res;
        end
        checkField(beh, "retire.memWrite", isStore, retire.memWrite);
        if (beh == 5) checkField(5, "retire.memAddr", addr, retire.memAddr);
        if (isStore) begin
            checkField(5, "retire.memData", b, retire.memData);
            mMem[addr[7:2]] = b;
        end
        if (!isStore && rd == 0) x0Written = 1'b1;
        prevRd = wr ? rd : 5'd0;
        mPc = {24'b0, mPc[7:0] + 8'd4};    // PC wraps at 256
        retired++;
    endtask

    // Sample retire half a cycle after it is registered
    always @(negedge CLK) begin
        if (RST) begin
            checkField(1, "retire.valid", 32'd0, retire.valid);
        end else if (retired < NUM_RETIRE) begin
            lowCycles++;
            checkField(1, "retire.valid", lowCycles >= 4, retire.valid);
            if (retire.valid && lowCycles >= 4) checkRetire();
        end
    end

    always @(posedge CLK) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles with only %0d of %0d instructions retired",
                     cycleCount, retired, NUM_RETIRE);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic string behaviorName(input int b);
        case (b)
            1: return "reset and order";
            2: return "register ALU operations";
            3: return "immediate operations";
            4: return "dependency bypass";
            5: return "memory";
            default: return "register zero";
        endcase
    endfunction

    task automatic report();
        int  total;
        int  failed;
        bit  unreached;
        total     = 0;
        failed    = 0;
        unreached = 1'b0;
        for (int b = 1; b <= 6; b++) begin
            $display("Behavior %0d, %s: %0d checks, %0d failed",
                     b, behaviorName(b), checks[b], fails[b]);
            if (checks[b] == 0) begin
                $display("Behavior %0d was never exercised by the program", b);
                unreached = 1'b1;
            end
            total  += checks[b];
            failed += fails[b];
        end
        $display("Checks passed: %0d, failed: %0d", total - failed, failed);
        if (failed == 0 && !unreached) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    initial begin
        RST        = 1'b1;
        progWrite  = 1'b0;
        progAddr   = '0;
        progData   = '0;
        lfsr       = 32'h14e198d0;
        mPc        = '0;
        prevRd     = '0;
        x0Written  = 1'b0;
        retired    = 0;
        lowCycles  = 0;
        cycleCount = 0;
        for (int i = 0; i < `CPU_REGS; i++) mRegs[i] = '0;
        for (int i = 0; i < `DMEM_WORDS; i++) mMem[i] = '0;
        for (int b = 1; b <= 6; b++) begin
            checks[b] = 0;
            fails[b]  = 0;
        end
        buildProgram();

        repeat (10) @(posedge CLK);
        for (int i = 0; i < `IMEM_WORDS; i++) begin   // Load while still in reset
            @(posedge CLK);
            #1;
            progWrite = 1'b1;
            progAddr  = i[`IMEM_AW-1:0];
            progData  = prog[i];
        end
        @(posedge CLK);
        #1;
        progWrite = 1'b0;
        RST       = 1'b0;

        while (retired < NUM_RETIRE) @(posedge CLK);
        report();
    end

endmodule

// File: singleCpu.sv
`include "cpu_consts.svh"

module singleCpu import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  progWrite,
    input  logic [`IMEM_AW-1:0]   progAddr,
    input  logic [`CPU_XLEN-1:0]  progData,
    output retire_t               retire
);

    fetchOut_t            fetchBus;
    decodeOut_t           decodeBus;
    wbReq_t               wbBus;
    logic [`REG_AW-1:0]   rs1Addr;
    logic [`REG_AW-1:0]   rs2Addr;
    logic [`CPU_XLEN-1:0] rs1Data;
    logic [`CPU_XLEN-1:0] rs2Data;

    fetchStage fetch (
        .CLK       (CLK),
        .RST       (RST),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .fetchOut  (fetchBus)
    );

    decodeStage decode (
        .CLK       (CLK),
        .RST       (RST),
        .fetchIn   (fetchBus),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .decodeOut (decodeBus)
    );

    registerFile regFile (
        .CLK       (CLK),
        .RST       (RST),
        .rs1Addr   (rs1Addr),
        .rs2Addr   (rs2Addr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .wbReq     (wbBus)
    );

    executeStage execute (
        .CLK       (CLK),
        .RST       (RST),
        .decodeIn  (decodeBus),
        .wbReq     (wbBus),
        .retire    (retire)
    );

endmodule

// File: executeStage.sv
`include "cpu_consts.svh"

module executeStage import cpu_pkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  decodeOut_t  decodeIn,
    output wbReq_t      wbReq,
    output retire_t     retire
);

    logic [`CPU_XLEN-1:0] dmem [`DMEM_WORDS];

    logic [`CPU_XLEN-1:0] op1;
    logic [`CPU_XLEN-1:0] op2;
    logic [4:0]           shamt;
    logic [`CPU_XLEN-1:0] aluResult;
    logic [`DMEM_AW-1:0]  memIdx;
    logic [`CPU_XLEN-1:0] loadData;
    logic [`CPU_XLEN-1:0] wbData;
    logic                 doStore;
    logic                 doWrite;
    retire_t              retireNext;

    assign op1   = decodeIn.rs1Data;
    assign op2   = decodeIn.aluSrc ? decodeIn.imm : decodeIn.rs2Data;
    assign shamt = op2[4:0];

    always_comb begin
        case (decodeIn.aluOp)
            ALU_ADD:  aluResult = op1 + op2;
            ALU_SUB:  aluResult = op1 - op2;
            ALU_AND:  aluResult = op1 & op2;
            ALU_OR:   aluResult = op1 | op2;
            ALU_XOR:  aluResult = op1 ^ op2;
            ALU_SLL:  aluResult = op1 << shamt;
            ALU_SRL:  aluResult = op1 >> shamt;
            ALU_SRA:  aluResult = $signed(op1) >>> shamt;
            ALU_SLT:  aluResult = {31'b0, $signed(op1) < $signed(op2)};
            ALU_SLTU: aluResult = {31'b0, op1 < op2};
            default:  aluResult = '0;
        endcase
    end

    // Word index of the effective address, wraps at memory depth
    assign memIdx   = aluResult[`DMEM_AW+1:2];
    assign loadData = dmem[memIdx];             // Asynchronous read
    assign doStore  = decodeIn.valid && decodeIn.memWrite;

    always_ff @(posedge CLK) begin
        if (doStore) begin
            dmem[memIdx] <= decodeIn.rs2Data;
        end
    end

    assign wbData  = decodeIn.memRead ? loadData : aluResult;
    assign doWrite = decodeIn.valid && decodeIn.regWrite;

    always_comb begin
        wbReq.we   = doWrite;
        wbReq.addr = decodeIn.rdAddr;
        wbReq.data = wbData;
    end

    // Retire shows the architectural effect, so x0 writes report nothing
    always_comb begin
        retireNext.valid    = decodeIn.valid;
        retireNext.pc       = decodeIn.pc;
        retireNext.instr    = decodeIn.instr;
        retireNext.rdWrite  = doWrite && (decodeIn.rdAddr != '0);
        retireNext.rdAddr   = decodeIn.rdAddr;
        retireNext.rdData   = retireNext.rdWrite ? wbData : '0;
        retireNext.memWrite = doStore;
        retireNext.memAddr  = (decodeIn.memRead || decodeIn.memWrite) ? aluResult : '0;
        retireNext.memData  = doStore ? decodeIn.rs2Data : '0;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire.valid <= 1'b0;
        end else begin
            retire <= retireNext;
        end
    end

endmodule

// File: decodeStage.sv
`include "cpu_consts.svh"

module decodeStage import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RST,
    input  fetchOut_t             fetchIn,
    output logic [`REG_AW-1:0]    rs1Addr,
    output logic [`REG_AW-1:0]    rs2Addr,
    input  logic [`CPU_XLEN-1:0]  rs1Data,
    input  logic [`CPU_XLEN-1:0]  rs2Data,
    output decodeOut_t            decodeOut
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 bit30;
    logic [`CPU_XLEN-1:0] iImm;
    logic [`CPU_XLEN-1:0] sImm;
    logic                 supported;
    decodeOut_t           decodeNext;

    // ALU control from {bit30, funct3}; sub only exists in register form
    function automatic aluOp_e aluCtrl(input logic isImm, input logic b30,
                                       input logic [2:0] f3);
        aluOp_e op;
        case (f3)
            `F3_ADD:  op = (b30 && !isImm) ? ALU_SUB : ALU_ADD;
            `F3_SLL:  op = ALU_SLL;
            `F3_SLT:  op = ALU_SLT;
            `F3_SLTU: op = ALU_SLTU;
            `F3_XOR:  op = ALU_XOR;
            `F3_SR:   op = b30 ? ALU_SRA : ALU_SRL;
            `F3_OR:   op = ALU_OR;
            default:  op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode  = fetchIn.instr[6:0];
    assign funct3  = fetchIn.instr[14:12];
    assign bit30   = fetchIn.instr[30];
    assign rs1Addr = fetchIn.instr[19:15];
    assign rs2Addr = fetchIn.instr[24:20];

    assign iImm = {{20{fetchIn.instr[31]}}, fetchIn.instr[31:20]};
    assign sImm = {{20{fetchIn.instr[31]}}, fetchIn.instr[31:25], fetchIn.instr[11:7]};

    always_comb begin
        decodeNext.pc       = fetchIn.pc;
        decodeNext.instr    = fetchIn.instr;
        decodeNext.rdAddr   = fetchIn.instr[11:7];
        decodeNext.rs1Data  = rs1Data;
        decodeNext.rs2Data  = rs2Data;
        decodeNext.aluOp    = ALU_ADD;   // Address calc for lw and sw
        decodeNext.aluSrc   = 1'b1;
        decodeNext.memRead  = 1'b0;
        decodeNext.memWrite = 1'b0;
        decodeNext.regWrite = 1'b0;
        decodeNext.imm      = iImm;
        supported           = 1'b1;

        case (opcode)
            `OPC_OP: begin
                decodeNext.aluOp    = aluCtrl(1'b0, bit30, funct3);
                decodeNext.aluSrc   = 1'b0;
                decodeNext.regWrite = 1'b1;
            end
            `OPC_OPIMM: begin
                decodeNext.aluOp    = aluCtrl(1'b1, bit30, funct3);
                decodeNext.regWrite = 1'b1;
            end
            `OPC_LOAD: begin
                decodeNext.memRead  = 1'b1;
                decodeNext.regWrite = 1'b1;
                supported           = (funct3 == `F3_WORD);   // lw only
            end
            `OPC_STORE: begin
                decodeNext.memWrite = 1'b1;
                decodeNext.imm      = sImm;
                supported           = (funct3 == `F3_WORD);   // sw only
            end
            default: supported = 1'b0;   // Becomes a bubble
        endcase

        decodeNext.valid = fetchIn.valid && supported;
    end

    // Decode to execute register
    always_ff @(posedge CLK) begin
        if (RST) begin
            decodeOut.valid <= 1'b0;
        end else begin
            decodeOut <= decodeNext;
        end
    end

endmodule

// File: registerFile.sv
`include "cpu_consts.svh"

module registerFile import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic [`REG_AW-1:0]    rs1Addr,
    input  logic [`REG_AW-1:0]    rs2Addr,
    output logic [`CPU_XLEN-1:0]  rs1Data,
    output logic [`CPU_XLEN-1:0]  rs2Data,
    input  wbReq_t                wbReq
);

    logic [`CPU_XLEN-1:0] regs [1:`CPU_REGS-1];   // x0 has no storage
    logic                 wbActive;

    assign wbActive = wbReq.we && (wbReq.addr != '0);

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < `CPU_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wbActive) begin
            regs[wbReq.addr] <= wbReq.data;
        end
    end

    // Read with write-through bypass
    always_comb begin
        if (rs1Addr == '0) rs1Data = '0;
        else if (wbActive && wbReq.addr == rs1Addr) rs1Data = wbReq.data;
        else rs1Data = regs[rs1Addr];

        if (rs2Addr == '0) rs2Data = '0;
        else if (wbActive && wbReq.addr == rs2Addr) rs2Data = wbReq.data;
        else rs2Data = regs[rs2Addr];
    end

endmodule

// File: fetchStage.sv
`include "cpu_consts.svh"

module fetchStage import cpu_pkg::*; (
    input  logic                  CLK,
    input  logic                  RST,
    input  logic                  progWrite,
    input  logic [`IMEM_AW-1:0]   progAddr,
    input  logic [`CPU_XLEN-1:0]  progData,
    output fetchOut_t             fetchOut
);

    logic [`CPU_XLEN-1:0] imem [`IMEM_WORDS];

    logic [`IMEM_AW-1:0]  pcIdx;     // Word index, wraps at memory depth
    logic [`CPU_XLEN-1:0] pc;
    fetchOut_t            fetchNext;

    assign pc = {{(`CPU_XLEN-`IMEM_AW-2){1'b0}}, pcIdx, 2'b00};

    // Program load port
    always_ff @(posedge CLK) begin
        if (progWrite) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            pcIdx <= '0;              // Holds 0 through reset
        end else begin
            pcIdx <= pcIdx + 1'b1;    // pc + 4
        end
    end

    always_comb begin
        fetchNext.valid = 1'b1;
        fetchNext.pc    = pc;
        fetchNext.instr = imem[pcIdx];
    end

    // Fetch to decode register
    always_ff @(posedge CLK) begin
        if (RST) begin
            fetchOut.valid <= 1'b0;
        end else begin
            fetchOut <= fetchNext;
        end
    end

endmodule

// File: cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } aluOp_e;

    // Fetch to decode
    typedef struct packed {
        logic                  valid;
        logic [`CPU_XLEN-1:0]  pc;
        logic [`CPU_XLEN-1:0]  instr;
    } fetchOut_t;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        logic [`CPU_XLEN-1:0]  pc;
        logic [`CPU_XLEN-1:0]  instr;
        aluOp_e                aluOp;
        logic                  aluSrc;     // 1 selects imm as second operand
        logic                  memRead;
        logic                  memWrite;
        logic                  regWrite;
        logic [`REG_AW-1:0]    rdAddr;
        logic [`CPU_XLEN-1:0]  rs1Data;
        logic [`CPU_XLEN-1:0]  rs2Data;
        logic [`CPU_XLEN-1:0]  imm;
    } decodeOut_t;

    // Execute to register file
    typedef struct packed {
        logic                  we;
        logic [`REG_AW-1:0]    addr;
        logic [`CPU_XLEN-1:0]  data;
    } wbReq_t;

    // One record per retired instruction
    typedef struct packed {
        logic                  valid;
        logic [`CPU_XLEN-1:0]  pc;
        logic [`CPU_XLEN-1:0]  instr;
        logic                  rdWrite;
        logic [`REG_AW-1:0]    rdAddr;
        logic [`CPU_XLEN-1:0]  rdData;
        logic                  memWrite;
        logic [`CPU_XLEN-1:0]  memAddr;
        logic [`CPU_XLEN-1:0]  memData;
    } retire_t;

endpackage

// File: cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and storage sizes
`define CPU_XLEN    32
`define CPU_REGS    32
`define REG_AW      5
`define IMEM_WORDS  64
`define IMEM_AW     6
`define DMEM_WORDS  64
`define DMEM_AW     6

// Major opcodes, instr[6:0]
`define OPC_OP      7'b0110011
`define OPC_OPIMM   7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011

// funct3 values
`define F3_ADD      3'b000  // add, sub, addi
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101  // srl, sra and immediate forms
`define F3_OR       3'b110
`define F3_AND      3'b111
`define F3_WORD     3'b010  // lw, sw

`endif
